//--- Bender.yml
package:
  name: uart_loader

export_include_dirs:
  - include

sources:
  - verilog/uart_pkg.sv
  - verilog/cmd_pkg.sv
  - verilog/mem_if.sv
  - verilog/uart_rx.sv
  - verilog/uart_tx.sv
  - verilog/cmd_engine.sv
  - verilog/word_mem.sv
  - verilog/uart_loader_top.sv
  - target: simulation
    files:
      - verif/uart_loader_tb.sv

//--- build.f
+incdir+include
verilog/uart_pkg.sv
verilog/cmd_pkg.sv
verilog/mem_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/cmd_engine.sv
verilog/word_mem.sv
verilog/uart_loader_top.sv
verif/uart_loader_tb.sv

//--- include/loader_settings.svh
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// uart bit time in clock cycles
`define CLKS_PER_BIT 5

// word memory geometry
`define MEM_DEPTH 64
`define ADDR_BITS 6     // log2 of MEM_DEPTH
`define WORD_BITS 32

`endif

//--- verif/uart_loader_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "loader_settings.svh"

module uart_loader_tb
    import cmd_pkg::*;
();
    localparam int CPB        = `CLKS_PER_BIT;
    localparam int N_WORDS    = 8;          // random write then read pairs
    localparam int N_OVER     = 4;          // addresses written twice
    localparam int START_WAIT = 4 * CPB;    // cycles allowed before a reply byte starts
    // frames on rxd and txd together, per test
    localparam int FRAMES     = N_WORDS * 12 + N_OVER * 18 + 16 + 29;
    localparam int IDLE_BITS  = 20 + 2 * 12 + 2;
    localparam int MARGIN_NS  = 20000;
    localparam int TIMEOUT_NS = (FRAMES * 10 + IDLE_BITS) * CPB * 40 * 2 + MARGIN_NS;

    logic clk;
    logic reset;
    logic rxd;
    logic txd;

    logic [`WORD_BITS-1:0] ref_mem [`MEM_DEPTH];   // last word written to each address
    integer                seed;

    uart_loader_top uut (
        .clk   (clk),
        .reset (reset),
        .rxd   (rxd),
        .txd   (txd)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic stop_on_error(input string msg);
        begin
            $display("FAIL at %0t: %s", $time, msg);
            $display("Errors found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // one 8N1 frame on rxd, lsb first
    task automatic send_byte(input logic [7:0] b, input logic bad_stop);
        int i;
        begin
            @(posedge clk);
            rxd <= 1'b0;
            repeat (CPB) @(posedge clk);
            for (i = 0; i < 8; i++) begin
                rxd <= b[i];
                repeat (CPB) @(posedge clk);
            end
            rxd <= !bad_stop;
            repeat (CPB) @(posedge clk);
            if (bad_stop) begin
                rxd <= 1'b1;   // back to idle so the next start edge is seen
                repeat (2 * CPB) @(posedge clk);
            end
        end
    endtask

    // returns in the middle of the stop bit
    task automatic recv_byte(output logic [7:0] b);
        logic [7:0] value;
        int         waited;
        int         i;
        begin
            waited = 0;
            @(negedge clk);
            while (txd !== 1'b0 && waited < START_WAIT) begin
                @(negedge clk);
                waited++;
            end
            assert (txd === 1'b0) else stop_on_error("no reply byte started on txd");
            repeat (CPB / 2) @(negedge clk);
            assert (txd === 1'b0) else stop_on_error("start bit on txd ended early");
            for (i = 0; i < 8; i++) begin
                repeat (CPB) @(negedge clk);
                value[i] = txd;
            end
            repeat (CPB) @(negedge clk);
            assert (txd === 1'b1) else stop_on_error("stop bit on txd was low");
            b = value;
        end
    endtask

    task automatic expect_quiet(input int bits);
        int i;
        begin
            for (i = 0; i < bits * CPB; i++) begin
                @(negedge clk);
                assert (txd === 1'b1) else stop_on_error("txd was active while it should idle");
            end
        end
    endtask

    task automatic write_word(input logic [`ADDR_BITS-1:0] addr,
                              input logic [`WORD_BITS-1:0] data);
        int i;
        begin
            send_byte(OP_WRITE, 1'b0);
            send_byte(8'(addr), 1'b0);
            for (i = 0; i < 4; i++) begin
                send_byte(data[8*i +: 8], 1'b0);   // low byte first
            end
            ref_mem[addr] = data;
        end
    endtask

    task automatic read_and_check(input logic [`ADDR_BITS-1:0] addr);
        logic [7:0]            got;
        logic [`WORD_BITS-1:0] expected;
        int                    i;
        begin
            expected = ref_mem[addr];
            send_byte(OP_READ, 1'b0);
            send_byte(8'(addr), 1'b0);
            for (i = 0; i < 4; i++) begin
                recv_byte(got);
                assert (got === expected[8*i +: 8]) else
                    stop_on_error($sformatf("read addr %0d byte %0d got %02h expected %02h",
                                            addr, i, got, expected[8*i +: 8]));
            end
            repeat (CPB) @(posedge clk);   // rest of the last stop bit
        end
    endtask

    task automatic check_nak(input logic [7:0] op);
        logic [7:0] got;
        begin
            send_byte(op, 1'b0);
            recv_byte(got);
            assert (got === NAK_BYTE) else
                stop_on_error($sformatf("opcode %02h got reply %02h expected %02h",
                                        op, got, NAK_BYTE));
            expect_quiet(12);   // one byte only
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [`ADDR_BITS-1:0] addr_list [N_WORDS];
        logic [`ADDR_BITS-1:0] addr;
        logic [`WORD_BITS-1:0] word_a;
        logic [`WORD_BITS-1:0] word_b;
        int                    i;

        reset = 1'b1;
        rxd   = 1'b1;
        seed  = 32'hedafa72a;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        expect_quiet(20);   // idle after reset

        for (i = 0; i < N_WORDS; i++) begin
            addr_list[i] = `ADDR_BITS'($random(seed));
            write_word(addr_list[i], $random(seed));
        end
        for (i = 0; i < N_WORDS; i++) begin
            read_and_check(addr_list[i]);
        end

        // overwrite
        for (i = 0; i < N_OVER; i++) begin
            addr = `ADDR_BITS'($random(seed));
            write_word(addr, $random(seed));
            write_word(addr, $random(seed));
            read_and_check(addr);
        end

        check_nak(8'h04);
        check_nak(8'hff);
        addr = `ADDR_BITS'($random(seed));
        write_word(addr, $random(seed));
        read_and_check(addr);

        // framing error in the middle of a write leaves the old word
        addr   = `ADDR_BITS'($random(seed));
        word_a = $random(seed);
        word_b = $random(seed);
        write_word(addr, word_a);
        send_byte(OP_WRITE, 1'b0);
        send_byte(8'(addr), 1'b0);
        send_byte(word_b[7:0], 1'b0);
        send_byte(word_b[15:8], 1'b0);
        send_byte(word_b[23:16], 1'b1);
        read_and_check(addr);
        write_word(addr, word_b);
        read_and_check(addr);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "loader_settings.svh"

module cmd_engine
    import cmd_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] rx_data,
    input  wire logic       rx_valid,
    input  wire logic       frame_err,
    output logic [7:0]      tx_data,
    output logic            tx_start,
    input  wire logic       tx_busy,
    mem_if.master           mem
);
    cmd_state_t            state;
    opcode_t               opcode_q;
    logic [`ADDR_BITS-1:0] addr_q;
    logic [`WORD_BITS-1:0] word_q;     // write data, then read data being sent
    logic [2:0]            byte_cnt;
    logic                  fetch;      // rdata valid this cycle
    logic                  tx_ready;
    logic                  send_word;
    logic                  send_nak;

    // tx_busy only rises the cycle after a start pulse
    assign tx_ready  = !tx_busy && !tx_start;
    assign send_word = (state == S_SEND) && !fetch && tx_ready && !byte_cnt[2];
    assign send_nak  = (state == S_NAK) && tx_ready && !byte_cnt[0];

    assign mem.we    = (state == S_WRITE);
    assign mem.addr  = addr_q;
    assign mem.wdata = word_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_OPCODE;
            byte_cnt <= '0;
            fetch    <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= send_word || send_nak;
            fetch    <= 1'b0;
            if (frame_err) begin
                state <= S_OPCODE;   // drop the partial command
            end else begin
                case (state)
                    S_OPCODE: begin
                        if (rx_valid) begin
                            byte_cnt <= '0;
                            if (rx_data == OP_WRITE || rx_data == OP_READ) begin
                                state <= S_ADDR;
                            end else begin
                                state <= S_NAK;
                            end
                        end
                    end
                    S_ADDR: begin
                        if (rx_valid) begin
                            state <= (opcode_q == OP_WRITE) ? S_DATA : S_READ;
                        end
                    end
                    S_DATA: begin
                        if (rx_valid) begin
                            byte_cnt <= byte_cnt + 3'd1;
                            if (byte_cnt == 3'd3) begin
                                state <= S_WRITE;
                            end
                        end
                    end
                    S_WRITE: state <= S_OPCODE;   // we high for this one cycle
                    S_READ: begin
                        byte_cnt <= '0;
                        fetch    <= 1'b1;
                        state    <= S_SEND;
                    end
                    S_SEND: begin
                        if (send_word) begin
                            byte_cnt <= byte_cnt + 3'd1;
                        end else if (byte_cnt[2] && tx_ready) begin
                            state <= S_OPCODE;   // last stop bit is out
                        end
                    end
                    S_NAK: begin
                        if (send_nak) begin
                            byte_cnt <= 3'd1;
                        end else if (byte_cnt[0] && tx_ready) begin
                            state <= S_OPCODE;
                        end
                    end
                    default: state <= S_OPCODE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && state == S_OPCODE) begin
            opcode_q <= opcode_t'(rx_data);
        end
        if (rx_valid && state == S_ADDR) begin
            addr_q <= rx_data[`ADDR_BITS-1:0];
        end
        if (rx_valid && state == S_DATA) begin
            word_q <= {rx_data, word_q[`WORD_BITS-1:8]};   // low byte arrives first
        end else if (state == S_SEND && fetch) begin
            word_q <= mem.rdata;
        end else if (send_word) begin
            word_q <= {8'h00, word_q[`WORD_BITS-1:8]};
        end
        if (send_word) begin
            tx_data <= word_q[7:0];
        end else if (send_nak) begin
            tx_data <= NAK_BYTE;
        end
    end

endmodule

`default_nettype wire

//--- verilog/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    typedef logic [7:0] byte_t;

    // any other opcode value gets a NAK
    typedef enum logic [7:0] {
        OP_WRITE = 8'h01,
        OP_READ  = 8'h02
    } opcode_t;

    typedef enum logic [2:0] {
        S_OPCODE,
        S_ADDR,
        S_DATA,
        S_WRITE,
        S_READ,
        S_SEND,
        S_NAK
    } cmd_state_t;

    localparam byte_t NAK_BYTE = 8'h15;   // ascii NAK

endpackage

`default_nettype wire

//--- verilog/mem_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "loader_settings.svh"

interface mem_if;
    logic                  we;
    logic [`ADDR_BITS-1:0] addr;
    logic [`WORD_BITS-1:0] wdata;
    logic [`WORD_BITS-1:0] rdata;   // valid one cycle after addr

    modport master (
        output we, addr, wdata,
        input  rdata
    );

    modport slave (
        input  we, addr, wdata,
        output rdata
    );
endinterface

`default_nettype wire

//--- verilog/uart_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loader_top (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic rxd,
    output logic      txd
);
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       frame_err;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    mem_if mem_bus ();

    uart_rx u_rx (
        .clk       (clk),
        .reset     (reset),
        .rxd       (rxd),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .frame_err (frame_err)
    );

    cmd_engine u_engine (
        .clk       (clk),
        .reset     (reset),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .frame_err (frame_err),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx_busy   (tx_busy),
        .mem       (mem_bus.master)
    );

    word_mem u_mem (
        .clk (clk),
        .mem (mem_bus.slave)
    );

    uart_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

//--- verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "loader_settings.svh"

module uart_rx
    import uart_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       rxd,
    output logic [7:0]      rx_data,
    output logic            rx_valid,
    output logic            frame_err
);
    localparam int CNT_BITS = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_BITS-1:0] BIT_LAST = CNT_BITS'(`CLKS_PER_BIT - 1);
    localparam logic [CNT_BITS-1:0] BIT_HALF = CNT_BITS'((`CLKS_PER_BIT - 1) / 2);

    logic [1:0]          sync_q;
    logic                rx_s;
    logic                rx_prev;
    rx_state_t           state;
    logic [CNT_BITS-1:0] cnt;
    logic [2:0]          bit_idx;

    assign rx_s = sync_q[1];

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q  <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            sync_q  <= {sync_q[0], rxd};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= RX_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt     <= CNT_BITS'(1);   // edge cycle counts as the first
                    bit_idx <= '0;
                    if (rx_prev && !rx_s) begin   // falling edge, not just a low line
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (cnt == BIT_HALF) begin
                        cnt   <= '0;
                        state <= rx_s ? RX_IDLE : RX_DATA;   // glitch goes back to idle
                    end else begin
                        cnt <= cnt + CNT_BITS'(1);
                    end
                end
                RX_DATA: begin
                    if (cnt == BIT_LAST) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end else begin
                        cnt <= cnt + CNT_BITS'(1);
                    end
                end
                RX_STOP: begin
                    if (cnt == BIT_LAST) begin
                        cnt       <= '0;
                        rx_valid  <= rx_s;
                        frame_err <= !rx_s;
                        state     <= RX_IDLE;
                    end else begin
                        cnt <= cnt + CNT_BITS'(1);
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first, bit lands in the msb and works down
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == BIT_LAST) begin
            rx_data <= {rx_s, rx_data[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "loader_settings.svh"

module uart_tx
    import uart_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] tx_data,
    input  wire logic       tx_start,
    output logic            txd,
    output logic            tx_busy
);
    localparam int CNT_BITS = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_BITS-1:0] BIT_LAST = CNT_BITS'(`CLKS_PER_BIT - 1);

    tx_state_t           state;
    logic [CNT_BITS-1:0] cnt;
    logic [2:0]          bit_idx;
    logic [7:0]          shreg;

    assign tx_busy = (state != TX_IDLE);   // exactly 10 bit times per byte

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (tx_start) begin
                        state <= TX_START;
                        txd   <= 1'b0;
                    end
                end
                TX_START: begin
                    if (cnt == BIT_LAST) begin
                        cnt   <= '0;
                        state <= TX_DATA;
                        txd   <= shreg[0];
                    end else begin
                        cnt <= cnt + CNT_BITS'(1);
                    end
                end
                TX_DATA: begin
                    if (cnt == BIT_LAST) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            txd     <= shreg[1];   // shreg shifts on this same edge
                        end
                    end else begin
                        cnt <= cnt + CNT_BITS'(1);
                    end
                end
                TX_STOP: begin
                    if (cnt == BIT_LAST) begin
                        state <= TX_IDLE;
                    end else begin
                        cnt <= cnt + CNT_BITS'(1);
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            shreg <= tx_data;
        end else if (state == TX_DATA && cnt == BIT_LAST) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- verilog/word_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "loader_settings.svh"

module word_mem (
    input wire logic clk,
    mem_if.slave     mem
);
    logic [`WORD_BITS-1:0] mem_array [`MEM_DEPTH];

    // single port, read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (mem.we) begin
            mem_array[mem.addr] <= mem.wdata;
        end
        mem.rdata <= mem_array[mem.addr];
    end

endmodule

`default_nettype wire
